/* project.f */
+incdir+include
design/snake_pkg.sv
design/game_sequencer.sv
design/snake_mover.sv
design/tile_map.sv
design/collision_judge.sv
design/snake_top.sv
testbench/snake_tb.sv

/* run_sim.sh */
#!/bin/bash
# build and run the snake testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f project.f --top-module snake_tb -o snake_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/snake_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
    exit 1
fi
exit 0

/* testbench/snake_tb.sv */
/*
  snake game testbench
  - clock, reset, step clock and mode stimulus
  - reference model of the body, eaten, won and lost
  - concurrent assertions against the model
*/

`timescale 1ns/100ps

`include "snake_consts.svh"

module snake_tb
    import snake_pkg::*;
();

    localparam int STEP_CYCLES = 8;
    localparam int MAX_CYCLES  = 40 * STEP_CYCLES + 20;

    logic clk, rst_n, step_clk;
    direction_e dir;
    game_mode_e mode;
    coord_t point;
    snake_t snake;
    map_t tiles;
    logic eaten, won, lost;

    // model of the DUT step and restart sampling
    logic sc_q1, sc_q2, restart_q;
    game_mode_e mode_q;
    coord_t body [`MAX_SNAKE_LENGTH];
    int body_len;
    coord_t vacated;
    logic vac_valid, exp_eaten_step, exp_misplaced;
    int errors = 0;
    int steps_seen = 0;
    int cycles = 0;

    snake_top i_dut (.clk(clk), .rst_n(rst_n), .step_clk(step_clk), .dir(dir), .mode(mode),
                     .point(point), .snake(snake), .tiles(tiles), .eaten(eaten), .won(won),
                     .lost(lost));

    always #50 clk = ~clk;

    function automatic coord_t make_coord(input int x, input int y);
        coord_t c;
        c.x = `WIDTH_BITS'(x);
        c.y = `HEIGHT_BITS'(y);
        return c;
    endfunction

    function automatic logic on_border(input coord_t c);
        return c.x == `WIDTH_BITS'(0) || c.x == `WIDTH_BITS'(`MAP_WIDTH - 1) ||
               c.y == `HEIGHT_BITS'(0) || c.y == `HEIGHT_BITS'(`MAP_HEIGHT - 1);
    endfunction

    function automatic logic in_body(input coord_t c, input int first);
        logic found;
        found = 1'b0;
        for (int k = first; k < body_len; k++) begin
            if (body[k] == c) found = 1'b1;
        end
        return found;
    endfunction

    // up is towards row 0, right towards the last column
    function automatic coord_t next_head(input coord_t h, input direction_e d);
        coord_t n;
        n = h;
        case (d)
            UP:      n.y = h.y - `HEIGHT_BITS'(1);
            DOWN:    n.y = h.y + `HEIGHT_BITS'(1);
            LEFT:    n.x = h.x - `WIDTH_BITS'(1);
            RIGHT:   n.x = h.x + `WIDTH_BITS'(1);
            default: n = h;
        endcase
        return n;
    endfunction

    function automatic logic model_dead();
        return body[0] == body[body_len-1] || on_border(body[0]) || in_body(body[0], 1);
    endfunction

    function automatic logic walls_intact();
        logic ok;
        ok = 1'b1;
        for (int i = 0; i < `MAP_HEIGHT; i++) begin
            for (int j = 0; j < `MAP_WIDTH; j++) begin
                if ((i == 0 || i == `MAP_HEIGHT - 1 || j == 0 || j == `MAP_WIDTH - 1) &&
                    !(int'(body[0].y) == i && int'(body[0].x) == j) && tiles[i][j] != WALL)
                    ok = 1'b0;
            end
        end
        return ok;
    endfunction

    function automatic logic body_on_map();
        logic ok;
        ok = 1'b1;
        for (int k = 0; k < body_len; k++) begin
            if (tiles[body[k].y][body[k].x] != SNAKE) ok = 1'b0;
        end
        return ok;
    endfunction

    // segment k points from body tile k+1 towards body tile k
    function automatic logic [3*`MAX_SNAKE_LENGTH-4:0] expected_segments();
        logic [3*`MAX_SNAKE_LENGTH-4:0] segs;
        coord_t a;
        coord_t b;
        for (int k = 0; k < `MAX_SNAKE_LENGTH - 1; k++) begin
            segs[3*k +: 3] = NONE;
            if (k < body_len - 1) begin
                a = body[k];
                b = body[k+1];
                if (a.y == b.y - `HEIGHT_BITS'(1)) begin
                    segs[3*k +: 3] = UP;
                end else if (a.y == b.y + `HEIGHT_BITS'(1)) begin
                    segs[3*k +: 3] = DOWN;
                end else if (a.x == b.x - `WIDTH_BITS'(1)) begin
                    segs[3*k +: 3] = LEFT;
                end else if (a.x == b.x + `WIDTH_BITS'(1)) begin
                    segs[3*k +: 3] = RIGHT;
                end
            end
        end
        return segs;
    endfunction

    task automatic flag_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        errors++;
        $display("FAILED at %0t: %s expected %0h got %0h", $time, name, expected, actual);
    endtask

    task automatic flag_problem(input string what);
        errors++;
        $display("FAILED at %0t: %s", $time, what);
    endtask

    always @(posedge clk) begin
        coord_t nh;
        logic grows;
        sc_q1     <= rst_n ? step_clk : 1'b0;
        sc_q2     <= rst_n ? sc_q1 : 1'b0;
        mode_q    <= mode;
        restart_q <= !rst_n || (mode == GAME && mode_q == MENU);
        if (!rst_n || restart_q) begin
            // body starts in one column, head on top
            for (int k = 0; k < `START_LENGTH; k++)
                body[k] = make_coord(`START_POS_X, `START_POS_Y + k);
            body_len       = `START_LENGTH;
            vac_valid      = 1'b0;
            exp_eaten_step = 1'b0;
            exp_misplaced  = 1'b0;
        end else begin
            exp_misplaced = on_border(point) || in_body(point, 0);
            if (sc_q1 && !sc_q2) begin
                nh             = next_head(body[0], dir);
                grows          = (nh == point);
                exp_eaten_step = grows;
                if (dir != NONE) begin
                    if (grows) begin
                        body_len++;
                    end else begin
                        vacated   = body[body_len-1];
                        vac_valid = 1'b1;
                    end
                    for (int k = `MAX_SNAKE_LENGTH - 1; k > 0; k--) body[k] = body[k-1];
                    body[0] = nh;
                end
                steps_seen++;
            end
        end
    end

    a_head: assert property (@(negedge clk) disable iff (!rst_n) snake.head == body[0])
        else flag_mismatch("snake.head", body[0], snake.head);
    a_tail: assert property (@(negedge clk) disable iff (!rst_n)
                             snake.tail == body[body_len-1])
        else flag_mismatch("snake.tail", body[body_len-1], snake.tail);
    a_length: assert property (@(negedge clk) disable iff (!rst_n) snake.length == 3'(body_len))
        else flag_mismatch("snake.length", body_len, snake.length);
    a_segments: assert property (@(negedge clk) disable iff (!rst_n)
                                 snake.segments == expected_segments())
        else flag_mismatch("snake.segments", expected_segments(), snake.segments);
    a_eaten: assert property (@(negedge clk) disable iff (!rst_n)
                              eaten == (exp_eaten_step || exp_misplaced))
        else flag_mismatch("eaten", exp_eaten_step || exp_misplaced, eaten);
    a_lost: assert property (@(negedge clk) disable iff (!rst_n) lost == model_dead())
        else flag_mismatch("lost", model_dead(), lost);
    a_won: assert property (@(negedge clk) disable iff (!rst_n)
                            won == (body_len == `MAX_SNAKE_LENGTH && !model_dead()))
        else flag_mismatch("won", body_len == `MAX_SNAKE_LENGTH && !model_dead(), won);
    a_walls: assert property (@(negedge clk) disable iff (!rst_n) walls_intact())
        else flag_problem("a border tile of tiles is not WALL");
    a_body: assert property (@(negedge clk) disable iff (!rst_n) body_on_map())
        else flag_problem("a tile under the snake body is not SNAKE");
    a_vacated: assert property (@(negedge clk) disable iff (!rst_n)
                                !vac_valid || tiles[vacated.y][vacated.x] == EMPTY)
        else flag_mismatch("tiles at old tail", EMPTY, tiles[vacated.y][vacated.x]);

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("summary: %0d errors, %0d steps, %0d cycles", errors, steps_seen, cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic take_step();
        @(negedge clk);
        step_clk = 1'b1;
        repeat (STEP_CYCLES / 2) @(negedge clk);
        step_clk = 1'b0;
        repeat (STEP_CYCLES / 2 - 1) @(negedge clk);
    endtask

    initial begin
        void'($urandom(32'he264fe92));
        clk      = 1'b0;
        rst_n    = 1'b0;
        step_clk = 1'b0;
        dir      = NONE;
        mode     = GAME;
        point    = make_coord(6, 6);
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (4) @(negedge clk);

        // up, point kept right of the body column
        dir   = UP;
        point = make_coord(4 + int'($urandom % 3), 1 + int'($urandom % 6));
        take_step();
        point = make_coord(`START_POS_X, 1);
        take_step();
        // the next step enters the top wall
        point = make_coord(4 + int'($urandom % 3), 1 + int'($urandom % 6));
        take_step();

        mode = MENU;
        repeat (2) @(negedge clk);
        mode = GAME;
        repeat (3) @(negedge clk);

        point = make_coord(0, int'($urandom % `MAP_HEIGHT));
        repeat (6) @(negedge clk);

        // eat three in a row towards the right wall
        dir = RIGHT;
        for (int k = 1; k <= 3; k++) begin
            point = make_coord(`START_POS_X + k, `START_POS_Y);
            take_step();
        end
        repeat (2) @(negedge clk);

        $display("summary: %0d errors, %0d steps, %0d cycles", errors, steps_seen, cycles);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* design/snake_top.sv */
/*
  snake game core top level
  - step and restart sequencing
  - snake movement, tile map and collision judging
*/

`timescale 1ns/100ps

module snake_top
    import snake_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       step_clk,
    input  direction_e dir,
    input  game_mode_e mode,
    input  coord_t     point,
    output snake_t     snake,
    output map_t       tiles,
    output logic       eaten,
    output logic       won,
    output logic       lost
);

    logic   step;
    logic   restart;
    coord_t head_next;
    logic   tail_moves;
    logic   eaten_step;
    tile_e  next_tile;

    game_sequencer i_game_sequencer (
        .clk      (clk),
        .rst_n    (rst_n),
        .step_clk (step_clk),
        .mode     (mode),
        .step     (step),
        .restart  (restart)
    );

    snake_mover i_snake_mover (
        .clk        (clk),
        .step       (step),
        .restart    (restart),
        .dir        (dir),
        .point      (point),
        .snake      (snake),
        .head_next  (head_next),
        .grow       (),
        .tail_moves (tail_moves),
        .eaten_step (eaten_step)
    );

    tile_map i_tile_map (
        .clk        (clk),
        .step       (step),
        .restart    (restart),
        .snake      (snake),
        .head_next  (head_next),
        .tail_moves (tail_moves),
        .point      (point),
        .eaten_step (eaten_step),
        .tiles      (tiles),
        .next_tile  (next_tile),
        .eaten      (eaten)
    );

    collision_judge i_collision_judge (
        .clk       (clk),
        .step      (step),
        .restart   (restart),
        .snake     (snake),
        .head_next (head_next),
        .next_tile (next_tile),
        .won       (won),
        .lost      (lost)
    );

endmodule

/* design/collision_judge.sv */
/*
  collision judge
  - registered wall, body and old tail flags per step
  - death decision
  - won and lost outputs
*/

`timescale 1ns/100ps

`include "snake_consts.svh"

module collision_judge
    import snake_pkg::*;
(
    input  logic   clk,
    input  logic   step,
    input  logic   restart,
    input  snake_t snake,
    input  coord_t head_next,
    input  tile_e  next_tile,
    output logic   won,
    output logic   lost
);

    logic hit_wall;
    logic hit_body;
    logic over_old_tail;
    logic died;

    always_ff @(posedge clk) begin
        if (restart) begin
            hit_wall      <= 1'b0;
            hit_body      <= 1'b0;
            over_old_tail <= 1'b0;
        end else if (step) begin
            hit_wall      <= (next_tile == WALL);
            hit_body      <= (next_tile == SNAKE);
            over_old_tail <= (head_next == snake.tail);
        end
    end

    // the old tail tile is vacated on the same step, so entering it is safe
    assign died = (snake.head == snake.tail) || (hit_body && !over_old_tail) || hit_wall;

    assign lost = died;
    assign won  = (snake.length == 3'(`MAX_SNAKE_LENGTH)) && !died;

endmodule

/* design/tile_map.sv */
/*
  tile map
  - border walls and starting body on restart
  - head, point and tail tile updates
  - tile under the next head
  - misplaced point check and the eaten flag
*/

`timescale 1ns/100ps

`include "snake_consts.svh"

module tile_map
    import snake_pkg::*;
(
    input  logic   clk,
    input  logic   step,
    input  logic   restart,
    input  snake_t snake,
    input  coord_t head_next,
    input  logic   tail_moves,
    input  coord_t point,
    input  logic   eaten_step,
    output map_t   tiles,
    output tile_e  next_tile,
    output logic   eaten
);

    map_t  tiles_next;
    logic  misplaced;
    tile_e point_tile;

    assign point_tile = tiles[point.y][point.x];
    assign next_tile  = tiles[head_next.y][head_next.x];

    always_comb begin
        for (int i = 0; i < `MAP_HEIGHT; i++) begin
            for (int j = 0; j < `MAP_WIDTH; j++) begin
                if (step && head_next.y == `HEIGHT_BITS'(i) && head_next.x == `WIDTH_BITS'(j)) begin
                    tiles_next[i][j] = SNAKE;
                end else if (snake.head.y == `HEIGHT_BITS'(i) &&
                             snake.head.x == `WIDTH_BITS'(j)) begin
                    tiles_next[i][j] = SNAKE;
                end else if (point.y == `HEIGHT_BITS'(i) && point.x == `WIDTH_BITS'(j) &&
                             tiles[i][j] == EMPTY) begin
                    tiles_next[i][j] = POINT;
                end else if (step && tail_moves && snake.tail.y == `HEIGHT_BITS'(i) &&
                             snake.tail.x == `WIDTH_BITS'(j)) begin
                    tiles_next[i][j] = EMPTY;
                end else begin
                    tiles_next[i][j] = tiles[i][j];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (restart) begin
            for (int i = 0; i < `MAP_HEIGHT; i++) begin
                for (int j = 0; j < `MAP_WIDTH; j++) begin
                    if (i == 0 || i == `MAP_HEIGHT - 1 || j == 0 || j == `MAP_WIDTH - 1) begin
                        tiles[i][j] <= WALL;
                    end else if (i >= `START_POS_Y && i < `START_POS_Y + `START_LENGTH &&
                                 j == `START_POS_X) begin
                        tiles[i][j] <= SNAKE;
                    end else begin
                        tiles[i][j] <= EMPTY;
                    end
                end
            end
            misplaced <= 1'b0;
        end else begin
            tiles     <= tiles_next;
            // point dropped on a wall or the body
            misplaced <= (point_tile == WALL) || (point_tile == SNAKE);
        end
    end

    assign eaten = eaten_step | misplaced;

endmodule

/* design/snake_mover.sv */
/*
  snake mover
  - next head from the direction input
  - eat detection and growth
  - tail advance along the oldest segment
  - segment list shift and the registered snake state
*/

`timescale 1ns/100ps

`include "snake_consts.svh"

module snake_mover
    import snake_pkg::*;
(
    input  logic       clk,
    input  logic       step,
    input  logic       restart,
    input  direction_e dir,
    input  coord_t     point,
    output snake_t     snake,
    output coord_t     head_next,
    output logic       grow,
    output logic       tail_moves,
    output logic       eaten_step
);

    snake_t     snake_next;
    logic [2:0] oldest_idx;
    direction_e oldest_seg;

    assign oldest_idx = snake.length - 3'd2;
    assign oldest_seg = snake.segments[oldest_idx];

    // y grows downwards, x grows to the right
    always_comb begin
        head_next = snake.head;
        case (dir)
            UP:      head_next.y = snake.head.y - `HEIGHT_BITS'(1);
            DOWN:    head_next.y = snake.head.y + `HEIGHT_BITS'(1);
            LEFT:    head_next.x = snake.head.x - `WIDTH_BITS'(1);
            RIGHT:   head_next.x = snake.head.x + `WIDTH_BITS'(1);
            default: head_next = snake.head;
        endcase
    end

    assign grow       = (head_next == point);
    assign tail_moves = (dir != NONE) && !grow;

    always_comb begin
        snake_next.head   = head_next;
        snake_next.length = grow ? snake.length + 3'd1 : snake.length;

        // tail stays put while growing
        snake_next.tail = snake.tail;
        if (tail_moves) begin
            case (oldest_seg)
                UP:      snake_next.tail.y = snake.tail.y - `HEIGHT_BITS'(1);
                DOWN:    snake_next.tail.y = snake.tail.y + `HEIGHT_BITS'(1);
                LEFT:    snake_next.tail.x = snake.tail.x - `WIDTH_BITS'(1);
                RIGHT:   snake_next.tail.x = snake.tail.x + `WIDTH_BITS'(1);
                default: snake_next.tail = snake.tail;
            endcase
        end

        // newest segment enters at index 0
        if (int'(snake_next.length) > 1) begin
            snake_next.segments[0] = (dir != NONE) ? dir : snake.segments[0];
        end else begin
            snake_next.segments[0] = NONE;
        end
        for (int k = 1; k < `MAX_SNAKE_LENGTH - 1; k++) begin
            if (k < int'(snake_next.length) - 1) begin
                if (dir != NONE) begin
                    snake_next.segments[k] = snake.segments[k-1];
                end else begin
                    snake_next.segments[k] = snake.segments[k];
                end
            end else begin
                snake_next.segments[k] = NONE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (restart) begin
            snake.head.x <= `WIDTH_BITS'(`START_POS_X);
            snake.head.y <= `HEIGHT_BITS'(`START_POS_Y);
            snake.tail.x <= `WIDTH_BITS'(`START_POS_X);
            snake.tail.y <= `HEIGHT_BITS'(`START_POS_Y + `START_LENGTH - 1);
            snake.length <= 3'(`START_LENGTH);
            // starting body points up towards the head
            for (int k = 0; k < `MAX_SNAKE_LENGTH - 1; k++) begin
                snake.segments[k] <= (k < `START_LENGTH - 1) ? UP : NONE;
            end
            eaten_step <= 1'b0;
        end else if (step) begin
            snake      <= snake_next;
            eaten_step <= grow;
        end
    end

endmodule

/* design/game_sequencer.sv */
/*
  game sequencer
  - step clock sampling in the clk domain
  - one-cycle step pulse on each step clock rising edge
  - restart pulse on reset or on a MENU to GAME change
*/

`timescale 1ns/100ps

module game_sequencer
    import snake_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       step_clk,
    input  game_mode_e mode,
    output logic       step,
    output logic       restart
);

    logic       step_clk_q1;
    logic       step_clk_q2;
    game_mode_e mode_prv;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            step_clk_q1 <= 1'b0;
            step_clk_q2 <= 1'b0;
            mode_prv    <= mode;
            restart     <= 1'b1;
        end else begin
            step_clk_q1 <= step_clk;
            step_clk_q2 <= step_clk_q1;
            mode_prv    <= mode;
            // entering the game starts a fresh round
            restart     <= (mode == GAME) && (mode_prv == MENU);
        end
    end

    // rising edge of the sampled step clock
    assign step = step_clk_q1 & ~step_clk_q2;

endmodule

/* design/snake_pkg.sv */
/*
  snake game types
  - direction and tile encodings
  - coordinate and snake state structs
  - tile map array and game mode
*/

`include "snake_consts.svh"

package snake_pkg;

    // move direction, also the direction of a stored segment
    typedef enum logic [2:0] {
        NONE,
        UP,
        DOWN,
        LEFT,
        RIGHT
    } direction_e;

    typedef enum logic [1:0] {
        EMPTY,
        WALL,
        SNAKE,
        POINT
    } tile_e;

    typedef struct packed {
        logic [`WIDTH_BITS-1:0]  x;
        logic [`HEIGHT_BITS-1:0] y;
    } coord_t;

    // segments[0] is next to the head, the oldest one is at length-2
    typedef struct packed {
        coord_t                                head;
        coord_t                                tail;
        logic [2:0]                            length;
        direction_e [`MAX_SNAKE_LENGTH-2:0]    segments;
    } snake_t;

    // indexed [y][x]
    typedef tile_e [`MAP_HEIGHT-1:0][`MAP_WIDTH-1:0] map_t;

    typedef enum logic {
        MENU,
        GAME
    } game_mode_e;

endpackage

/* include/snake_consts.svh */
/*
  snake game constants
  - map size and coordinate widths
  - starting and winning snake lengths
  - starting head position
*/

`ifndef SNAKE_CONSTS_SVH
`define SNAKE_CONSTS_SVH

// map size, border tiles are walls
`define MAP_WIDTH        8
`define MAP_HEIGHT       8

// coordinate widths
`define WIDTH_BITS       3
`define HEIGHT_BITS      3

// snake lengths
`define MAX_SNAKE_LENGTH 6
`define START_LENGTH     3

// head start, body runs down the same column
`define START_POS_X      3
`define START_POS_Y      3

`endif
